/* vlog.f */
+incdir+rtl
rtl/rab_axi_pkg.sv
rtl/rab_slice_pkg.sv
rtl/rab_cfg_if.sv
rtl/miss_fifo.sv
rtl/miss_handler.sv
rtl/l1_cfg_regs.sv
rtl/axi_lite_slave.sv
rtl/rab_cfg_top.sv
tests/tb_rab_cfg.sv

/* Bender.yml */
package:
  name: rab_cfg

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rab_axi_pkg.sv
      - rtl/rab_slice_pkg.sv
      - rtl/rab_cfg_if.sv
      - rtl/miss_fifo.sv
      - rtl/miss_handler.sv
      - rtl/l1_cfg_regs.sv
      - rtl/axi_lite_slave.sv
      - rtl/rab_cfg_top.sv
      - target: test
        files:
          - tests/tb_rab_cfg.sv

/* tests/tb_rab_cfg.sv */
// RAB configuration port testbench
`include "rab_params_cfg.svh"

module tb_rab_cfg;

  localparam int          WAIT_LIMIT = 200; // Cycles per wait loop
  localparam logic [63:0] ALL_ONES   = {64{1'b1}};
  localparam logic [63:0] EMPTY_BIT  = 64'h8000_0000_0000_0000;

  logic                             Clk_CI;
  logic                             Rst_RBI;
  logic [`RAB_AXI_ADDR_WIDTH-1:0]   s_axi_awaddr;
  logic                             s_axi_awvalid;
  logic                             s_axi_awready;
  logic [`RAB_AXI_DATA_WIDTH-1:0]   s_axi_wdata;
  logic [`RAB_AXI_DATA_WIDTH/8-1:0] s_axi_wstrb;
  logic                             s_axi_wvalid;
  logic                             s_axi_wready;
  logic [1:0]                       s_axi_bresp;
  logic                             s_axi_bvalid;
  logic                             s_axi_bready;
  logic [`RAB_AXI_ADDR_WIDTH-1:0]   s_axi_araddr;
  logic                             s_axi_arvalid;
  logic                             s_axi_arready;
  logic [`RAB_AXI_DATA_WIDTH-1:0]   s_axi_rdata;
  logic [1:0]                       s_axi_rresp;
  logic                             s_axi_rvalid;
  logic                             s_axi_rready;
  rab_slice_pkg::cfg_word_t         L1Cfg_DO [`RAB_N_REGS];
  logic [`RAB_VIRT_WIDTH-1:0]       MissAddr_DI;
  logic [`RAB_MISS_ID_WIDTH-1:0]    MissId_DI;
  logic                             Miss_SI;
  logic                             MhFifoFull_SO;

  logic [63:0]                      shadow [`RAB_N_REGS];
  logic [`RAB_VIRT_WIDTH-1:0]       addr_mq [$]; // Expected miss queues
  logic [`RAB_MISS_ID_WIDTH-1:0]    id_mq [$];
  logic [63:0]                      got_q [$];
  logic [63:0]                      exp_q [$];
  string                            tag_q [$];
  int                               n_checks;
  int                               n_errors;
  int                               max_stall;

  rab_cfg_top dut (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #4 Clk_CI = ~Clk_CI;
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Register content after a write, from the field rules
  function automatic logic [63:0] expected_word(input logic [63:0] old, input int idx,
                                                input logic [63:0] data, input logic [7:0] strb);
    logic [63:0] keep;
    logic [63:0] res;
    res = old;
    if (idx < 2 || idx >= `RAB_N_REGS)
      return old;
    if (idx % 4 < 2)
      keep = (64'd1 << `RAB_VIRT_WIDTH) - 64'd1;
    else if (idx % 4 == 2)
      keep = (64'd1 << `RAB_PHYS_WIDTH) - 64'd1;
    else
      keep = (64'd1 << `RAB_N_FLAGS) - 64'd1;
    for (int b = 0; b < 8; b++)
    begin
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8] & keep[8*b +: 8];
    end
    return res;
  endfunction

  // Read results are compared here as they arrive
  always @(negedge Clk_CI)
  begin
    while (exp_q.size() > 0)
      check(got_q.pop_front(), exp_q.pop_front(), tag_q.pop_front());
  end

  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    int   t;
    int   stall;
    logic aw_go;
    logic w_go;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wvalid  = 1'b1;
    t = 0;
    while (s_axi_awvalid || s_axi_wvalid)
    begin
      aw_go = s_axi_awvalid && s_axi_awready; // Handshake at the coming edge
      w_go  = s_axi_wvalid && s_axi_wready;
      @(negedge Clk_CI);
      if (aw_go)
        s_axi_awvalid = 1'b0;
      if (w_go)
        s_axi_wvalid = 1'b0;
      if (++t > WAIT_LIMIT)
        abort_on_timeout("the AW and W handshakes");
    end
    t = 0;
    while (!s_axi_bvalid)
    begin
      @(negedge Clk_CI);
      if (++t > WAIT_LIMIT)
        abort_on_timeout("bvalid");
    end
    check(s_axi_awready || s_axi_wready, 0, "AW or W ready while B pending");
    stall = $urandom_range(0, max_stall);
    repeat (stall)
    begin
      @(negedge Clk_CI);
      check(s_axi_bvalid, 1, "bvalid held under back-pressure");
    end
    check(s_axi_bresp, 2'b00, "bresp");
    s_axi_bready = 1'b1;
    @(negedge Clk_CI);
    s_axi_bready = 1'b0;
    check(s_axi_awready && s_axi_wready, 1, "AW and W ready after the B handshake");
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [63:0] exp,
                          input logic [63:0] mask, input string what);
    int          t;
    int          stall;
    logic [63:0] first;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    t = 0;
    while (!s_axi_arready)
    begin
      @(negedge Clk_CI);
      if (++t > WAIT_LIMIT)
        abort_on_timeout("arready");
    end
    @(negedge Clk_CI);
    s_axi_arvalid = 1'b0;
    t = 0;
    while (!s_axi_rvalid)
    begin
      @(negedge Clk_CI);
      if (++t > WAIT_LIMIT)
        abort_on_timeout("rvalid");
    end
    check(s_axi_arready, 0, "arready while R pending");
    first = s_axi_rdata;
    stall = $urandom_range(0, max_stall);
    repeat (stall)
    begin
      @(negedge Clk_CI);
      check(s_axi_rvalid, 1, "rvalid held under back-pressure");
      check(s_axi_rdata, first, "rdata stable under back-pressure");
    end
    check(s_axi_rresp, 2'b00, "rresp");
    got_q.push_back(s_axi_rdata & mask);
    exp_q.push_back(exp & mask);
    tag_q.push_back(what);
    s_axi_rready = 1'b1;
    @(negedge Clk_CI);
    s_axi_rready = 1'b0;
    check(s_axi_arready, 1, "arready after the R handshake");
  endtask

  // Write one index and track it in the shadow array
  task automatic write_reg(input int idx, input logic [7:0] strb);
    logic [63:0] data;
    data = {$urandom, $urandom};
    axi_write(idx << `RAB_ADDR_LSB, data, strb);
    if (idx < `RAB_N_REGS)
      shadow[idx] = expected_word(shadow[idx], idx, data, strb);
  endtask

  task automatic check_cfg_out();
    for (int i = 0; i < `RAB_N_REGS; i++)
      check(L1Cfg_DO[i], shadow[i], $sformatf("L1Cfg_DO[%0d]", i));
  endtask

  task automatic pulse_misses(input int n);
    logic full_exp;
    for (int i = 0; i < n; i++)
    begin
      MissAddr_DI = $urandom;
      MissId_DI   = $urandom;
      Miss_SI     = 1'b1;
      full_exp    = (addr_mq.size() >= `RAB_MH_FIFO_DEPTH) ||
                    (id_mq.size() >= `RAB_MH_FIFO_DEPTH);
      #1;
      check(MhFifoFull_SO, full_exp, "MhFifoFull_SO");
      if (!full_exp)
      begin
        addr_mq.push_back(MissAddr_DI);
        id_mq.push_back(MissId_DI);
      end
      @(negedge Clk_CI);
    end
    Miss_SI = 1'b0;
  endtask

  task automatic pop_addresses(input int n);
    for (int i = 0; i < n; i++)
      axi_read(0, {32'b0, addr_mq.pop_front()}, ALL_ONES, "miss address");
  endtask

  task automatic drain_misses();
    while (addr_mq.size() > 0 || id_mq.size() > 0)
    begin
      if (addr_mq.size() > 0)
        axi_read(0, {32'b0, addr_mq.pop_front()}, ALL_ONES, "miss address");
      if (id_mq.size() > 0)
        axi_read(8, {54'b0, id_mq.pop_front()}, ALL_ONES, "miss ID");
    end
    axi_read(0, EMPTY_BIT, EMPTY_BIT, "address FIFO empty flag");
    axi_read(8, EMPTY_BIT, EMPTY_BIT, "ID FIFO empty flag");
  endtask

  initial
  begin
    int idx;
    void'($urandom(32'h312a));
    n_checks      = 0;
    n_errors      = 0;
    max_stall     = 2;
    Rst_RBI       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    MissAddr_DI   = '0;
    MissId_DI     = '0;
    Miss_SI       = 1'b0;
    for (int i = 0; i < `RAB_N_REGS; i++)
      shadow[i] = '0;
    repeat (16) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);
    check(s_axi_awready, 1, "awready after reset");
    check(s_axi_wready, 1, "wready after reset");
    check(s_axi_arready, 1, "arready after reset");
    check(s_axi_bvalid, 0, "bvalid after reset");
    check(s_axi_rvalid, 0, "rvalid after reset");
    check(MhFifoFull_SO, 0, "MhFifoFull_SO after reset");
    check_cfg_out();

    // Virtual address indices keep 32 bits
    for (int n = 0; n < 30; n++)
    begin
      idx = 4 * $urandom_range(1, 3) + $urandom_range(0, 1);
      write_reg(idx, $urandom);
      check_cfg_out();
      axi_read(idx << `RAB_ADDR_LSB, shadow[idx], ALL_ONES, "virtual address readback");
    end

    // Physical address and flag indices with partial strobes
    for (int n = 0; n < 30; n++)
    begin
      idx = 4 * $urandom_range(0, 3) + 2 + $urandom_range(0, 1);
      write_reg(idx, $urandom);
      check_cfg_out();
      axi_read(idx << `RAB_ADDR_LSB, shadow[idx], ALL_ONES, "phys/flags readback");
    end

    // Reserved and out-of-range writes are dropped
    write_reg(0, 8'hff);
    write_reg(1, 8'hff);
    axi_write(`RAB_N_REGS << `RAB_ADDR_LSB, {$urandom, $urandom}, 8'hff);
    axi_write(32'h1000_0010, {$urandom, $urandom}, 8'hff); // Aliases index 2 in low bits
    check_cfg_out();
    axi_read(`RAB_N_REGS << `RAB_ADDR_LSB, '0, ALL_ONES, "out-of-range read");
    axi_read(32'h8000_0018, '0, ALL_ONES, "out-of-range read");

    // Misses in arrival order, then overflow with drops
    drain_misses();
    pulse_misses(5);
    drain_misses();
    pulse_misses(`RAB_MH_FIFO_DEPTH + 3);
    drain_misses();
    pulse_misses(3);
    pop_addresses(2); // Queues now unequal in fill
    pulse_misses(`RAB_MH_FIFO_DEPTH);
    drain_misses();

    // Long back-pressure on B and R
    max_stall = 8;
    for (int n = 0; n < 30; n++)
    begin
      idx = $urandom_range(2, `RAB_N_REGS - 1);
      if ($urandom_range(0, 1))
        write_reg(idx, $urandom);
      else
        axi_read(idx << `RAB_ADDR_LSB, shadow[idx], ALL_ONES, "readback under stall");
    end
    check_cfg_out();

    repeat (2) @(negedge Clk_CI);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* rtl/rab_cfg_top.sv */
// RAB configuration port top level
`include "rab_params_cfg.svh"

module rab_cfg_top (
  input  logic                             Clk_CI,
  input  logic                             Rst_RBI,
  input  logic [`RAB_AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                             s_axi_awvalid,
  output logic                             s_axi_awready,
  input  logic [`RAB_AXI_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [`RAB_AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                             s_axi_wvalid,
  output logic                             s_axi_wready,
  output logic [1:0]                       s_axi_bresp,
  output logic                             s_axi_bvalid,
  input  logic                             s_axi_bready,
  input  logic [`RAB_AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic                             s_axi_arvalid,
  output logic                             s_axi_arready,
  output logic [`RAB_AXI_DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]                       s_axi_rresp,
  output logic                             s_axi_rvalid,
  input  logic                             s_axi_rready,
  output rab_slice_pkg::cfg_word_t         L1Cfg_DO [`RAB_N_REGS],
  input  rab_slice_pkg::miss_addr_t        MissAddr_DI,
  input  rab_slice_pkg::miss_id_t          MissId_DI,
  input  logic                             Miss_SI,
  output logic                             MhFifoFull_SO
);

  cfg_wr_if   wr_bus ();
  cfg_rd_if   rd_bus ();
  miss_pop_if pop_bus ();

  axi_lite_slave axi_slave_i (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .wr            (wr_bus),
    .rd            (rd_bus)
  );

  l1_cfg_regs regs_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .wr      (wr_bus),
    .rd      (rd_bus),
    .pop     (pop_bus),
    .cfg     (L1Cfg_DO)
  );

  miss_handler mh_i (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .miss_addr (MissAddr_DI),
    .miss_id   (MissId_DI),
    .miss      (Miss_SI),
    .pop       (pop_bus),
    .fifo_full (MhFifoFull_SO)
  );

endmodule

/* rtl/axi_lite_slave.sv */
// AXI4-Lite slave channel engine
`include "rab_params_cfg.svh"

module axi_lite_slave (
  input  logic                             Clk_CI,
  input  logic                             Rst_RBI,
  input  logic [`RAB_AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                             s_axi_awvalid,
  output logic                             s_axi_awready,
  input  logic [`RAB_AXI_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [`RAB_AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                             s_axi_wvalid,
  output logic                             s_axi_wready,
  output logic [1:0]                       s_axi_bresp,
  output logic                             s_axi_bvalid,
  input  logic                             s_axi_bready,
  input  logic [`RAB_AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic                             s_axi_arvalid,
  output logic                             s_axi_arready,
  output logic [`RAB_AXI_DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]                       s_axi_rresp,
  output logic                             s_axi_rvalid,
  input  logic                             s_axi_rready,
  cfg_wr_if.master                         wr,
  cfg_rd_if.master                         rd
);

  rab_axi_pkg::wr_state_e           wr_state_q;
  rab_axi_pkg::rd_state_e           rd_state_q;
  logic                             aw_done_q;
  logic                             w_done_q;
  logic                             wr_en_q;
  logic                             aw_hs;
  logic                             w_hs;
  logic                             ar_hs;
  logic                             aw_next;
  logic                             w_next;
  logic [`RAB_AXI_ADDR_WIDTH-1:0]   awaddr_q;
  logic [`RAB_AXI_ADDR_WIDTH-1:0]   araddr_q;
  rab_slice_pkg::cfg_word_t         wdata_q;
  logic [`RAB_AXI_DATA_WIDTH/8-1:0] wstrb_q;
  logic [`RAB_AXI_DATA_WIDTH-1:0]   rdata_q;

  assign s_axi_awready = (wr_state_q == rab_axi_pkg::WR_COLLECT) && !aw_done_q;
  assign s_axi_wready  = (wr_state_q == rab_axi_pkg::WR_COLLECT) && !w_done_q;
  assign s_axi_bvalid  = (wr_state_q == rab_axi_pkg::WR_RESP);
  assign s_axi_bresp   = rab_axi_pkg::OKAY;

  assign s_axi_arready = (rd_state_q == rab_axi_pkg::RD_IDLE);
  assign s_axi_rvalid  = (rd_state_q == rab_axi_pkg::RD_RESP);
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = rab_axi_pkg::OKAY;

  assign aw_hs   = s_axi_awvalid && s_axi_awready;
  assign w_hs    = s_axi_wvalid && s_axi_wready;
  assign ar_hs   = s_axi_arvalid && s_axi_arready;
  assign aw_next = aw_done_q || aw_hs;
  assign w_next  = w_done_q || w_hs;

  assign wr.wr_en   = wr_en_q;
  assign wr.wr_addr = awaddr_q;
  assign wr.wr_data = wdata_q;
  assign wr.wr_strb = wstrb_q;
  assign rd.rd_en   = (rd_state_q == rab_axi_pkg::RD_FETCH);
  assign rd.rd_addr = araddr_q;

  // Write FSM, AW and W captured in any order
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_state_q <= rab_axi_pkg::WR_COLLECT;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      wr_en_q    <= 1'b0;
    end
    else
    begin
      wr_en_q <= 1'b0;
      case (wr_state_q)
        rab_axi_pkg::WR_COLLECT:
        begin
          aw_done_q <= aw_next;
          w_done_q  <= w_next;
          if (aw_next && w_next)
          begin
            wr_state_q <= rab_axi_pkg::WR_RESP;
            wr_en_q    <= 1'b1; // Register write with bvalid rising
          end
        end
        default:
        begin
          if (s_axi_bready)
          begin
            wr_state_q <= rab_axi_pkg::WR_COLLECT;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
          end
        end
      endcase
    end
  end

  // Read FSM
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      rd_state_q <= rab_axi_pkg::RD_IDLE;
    else
    begin
      case (rd_state_q)
        rab_axi_pkg::RD_IDLE:  if (ar_hs) rd_state_q <= rab_axi_pkg::RD_FETCH;
        rab_axi_pkg::RD_FETCH: rd_state_q <= rab_axi_pkg::RD_RESP;
        rab_axi_pkg::RD_RESP:  if (s_axi_rready) rd_state_q <= rab_axi_pkg::RD_IDLE;
        default:               rd_state_q <= rab_axi_pkg::RD_IDLE;
      endcase
    end
  end

  // Channel payloads
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      awaddr_q <= s_axi_awaddr;
    if (w_hs)
    begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
    if (ar_hs)
      araddr_q <= s_axi_araddr;
    if (rd.rd_en)
      rdata_q <= rd.rd_data; // Held until the R handshake
  end

  // A register write only follows an accepted or absent B response
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr.wr_en |-> $past(!s_axi_bvalid || s_axi_bready));

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

/* rtl/l1_cfg_regs.sv */
// Slice configuration register file
`include "rab_params_cfg.svh"

module l1_cfg_regs (
  input  logic              Clk_CI,
  input  logic              Rst_RBI,
  cfg_wr_if.slave           wr,
  cfg_rd_if.slave           rd,
  miss_pop_if.regs          pop,
  output rab_slice_pkg::cfg_word_t cfg [`RAB_N_REGS]
);

  localparam int unsigned IDX_W   = $clog2(`RAB_N_REGS);
  localparam int unsigned N_BYTES = `RAB_AXI_DATA_WIDTH / 8;

  rab_slice_pkg::cfg_word_t regs_q [`RAB_N_REGS];
  rab_slice_pkg::field_e    wr_field;
  rab_slice_pkg::cfg_word_t wr_mask;
  logic [IDX_W-1:0]         wr_idx;
  logic [IDX_W-1:0]         rd_idx;
  logic                     wr_in_range;
  logic                     rd_in_range;
  logic                     wr_hit;

  assign wr_idx      = wr.wr_addr[`RAB_ADDR_LSB +: IDX_W];
  assign rd_idx      = rd.rd_addr[`RAB_ADDR_LSB +: IDX_W];
  assign wr_in_range = wr.wr_addr[`RAB_AXI_ADDR_WIDTH-1:`RAB_ADDR_LSB] < `RAB_N_REGS;
  assign rd_in_range = rd.rd_addr[`RAB_AXI_ADDR_WIDTH-1:`RAB_ADDR_LSB] < `RAB_N_REGS;
  assign wr_field    = rab_slice_pkg::field_of(wr_idx[1:0]);
  assign wr_mask     = rab_slice_pkg::field_mask(wr_field);
  assign wr_hit      = wr.wr_en && wr_in_range && (wr_idx > IDX_W'(1)); // Skip FIFO indices

  // Strobed bytes, masked down to the field width
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int i = 0; i < `RAB_N_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (wr_hit)
    begin
      for (int b = 0; b < N_BYTES; b++)
      begin
        if (wr.wr_strb[b])
          regs_q[wr_idx][b] <= wr.wr_data[b] & wr_mask[b];
      end
    end
  end

  assign cfg = regs_q;

  // Read decode, FIFO heads carry the empty flag in the top bit
  always_comb
  begin
    rd.rd_data   = '0;
    pop.addr_pop = 1'b0;
    pop.id_pop   = 1'b0;
    if (rd_in_range)
    begin
      case (rd_idx)
        IDX_W'(0):
        begin
          rd.rd_data[`RAB_AXI_DATA_WIDTH-1] = pop.addr_empty;
          rd.rd_data[`RAB_VIRT_WIDTH-1:0]   = pop.addr_head;
          pop.addr_pop                      = rd.rd_en && !pop.addr_empty;
        end
        IDX_W'(1):
        begin
          rd.rd_data[`RAB_AXI_DATA_WIDTH-1]  = pop.id_empty;
          rd.rd_data[`RAB_MISS_ID_WIDTH-1:0] = pop.id_head;
          pop.id_pop                         = rd.rd_en && !pop.id_empty;
        end
        default: rd.rd_data = regs_q[rd_idx];
      endcase
    end
  end

endmodule

/* rtl/miss_handler.sv */
// Paired miss address and ID queues
`include "rab_params_cfg.svh"

module miss_handler (
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  rab_slice_pkg::miss_addr_t miss_addr,
  input  rab_slice_pkg::miss_id_t   miss_id,
  input  logic                      miss,
  miss_pop_if.handler               pop,
  output logic                      fifo_full
);

  logic addr_full;
  logic id_full;
  logic push;

  // Both queues take the miss or neither does
  assign push      = miss && !addr_full && !id_full;
  assign fifo_full = miss && (addr_full || id_full); // Dropped report

  miss_fifo #(
    .WIDTH (`RAB_VIRT_WIDTH),
    .DEPTH (`RAB_MH_FIFO_DEPTH)
  ) addr_fifo_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push    (push),
    .pop     (pop.addr_pop),
    .din     (miss_addr),
    .dout    (pop.addr_head),
    .full    (addr_full),
    .empty   (pop.addr_empty)
  );

  miss_fifo #(
    .WIDTH (`RAB_MISS_ID_WIDTH),
    .DEPTH (`RAB_MH_FIFO_DEPTH)
  ) id_fifo_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push    (push),
    .pop     (pop.id_pop),
    .din     (miss_id),
    .dout    (pop.id_head),
    .full    (id_full),
    .empty   (pop.id_empty)
  );

endmodule

/* rtl/miss_fifo.sv */
// Synchronous circular FIFO
module miss_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 8
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign full    = (cnt_q == CNT_W'(DEPTH));
  assign empty   = (cnt_q == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign dout    = mem_q[rd_ptr_q]; // Head visible without a pop

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= din;
  end

  // Callers check the flags before they push or pop
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) push |-> !full);
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) pop |-> !empty);

endmodule

/* rtl/rab_cfg_if.sv */
// Register access and miss pop interfaces
`include "rab_params_cfg.svh"

interface cfg_wr_if;
  logic                              wr_en;   // One-cycle pulse
  logic [`RAB_AXI_ADDR_WIDTH-1:0]    wr_addr;
  rab_slice_pkg::cfg_word_t          wr_data;
  logic [`RAB_AXI_DATA_WIDTH/8-1:0]  wr_strb;

  modport master (output wr_en, output wr_addr, output wr_data, output wr_strb);
  modport slave  (input wr_en, input wr_addr, input wr_data, input wr_strb);
endinterface

interface cfg_rd_if;
  logic                              rd_en;   // One-cycle pulse
  logic [`RAB_AXI_ADDR_WIDTH-1:0]    rd_addr;
  logic [`RAB_AXI_DATA_WIDTH-1:0]    rd_data; // Combinational return

  modport master (output rd_en, output rd_addr, input rd_data);
  modport slave  (input rd_en, input rd_addr, output rd_data);
endinterface

interface miss_pop_if;
  rab_slice_pkg::miss_addr_t addr_head;
  logic                      addr_empty;
  logic                      addr_pop;
  rab_slice_pkg::miss_id_t   id_head;
  logic                      id_empty;
  logic                      id_pop;

  modport handler (
    output addr_head, output addr_empty, output id_head, output id_empty,
    input  addr_pop,  input  id_pop
  );
  modport regs (
    input  addr_head, input  addr_empty, input  id_head, input  id_empty,
    output addr_pop,  output id_pop
  );
endinterface

/* rtl/rab_slice_pkg.sv */
// Slice configuration types
`include "rab_params_cfg.svh"

package rab_slice_pkg;

  typedef enum logic [1:0] {
    FIELD_VIRT  = 2'b00,
    FIELD_PHYS  = 2'b10,
    FIELD_FLAGS = 2'b11
  } field_e;

  typedef logic [`RAB_AXI_DATA_WIDTH/8-1:0][7:0] cfg_word_t; // [Byte][Bit]

  typedef logic [`RAB_VIRT_WIDTH-1:0] miss_addr_t;
  typedef logic [`RAB_MISS_ID_WIDTH-1:0] miss_id_t;

  // Field kind from the two low index bits
  function automatic field_e field_of(logic [1:0] idx_lo);
    if (!idx_lo[1])
      return FIELD_VIRT;
    else if (idx_lo[0])
      return FIELD_FLAGS;
    else
      return FIELD_PHYS;
  endfunction

  // Bits a field kind keeps
  function automatic cfg_word_t field_mask(field_e kind);
    logic [`RAB_AXI_DATA_WIDTH-1:0] bits;
    bits = '0;
    case (kind)
      FIELD_PHYS:  bits[`RAB_PHYS_WIDTH-1:0] = '1;
      FIELD_FLAGS: bits[`RAB_N_FLAGS-1:0]    = '1;
      default:     bits[`RAB_VIRT_WIDTH-1:0] = '1;
    endcase
    return bits;
  endfunction

endpackage

/* rtl/rab_axi_pkg.sv */
// AXI-Lite types
package rab_axi_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  typedef enum logic {
    WR_COLLECT, // Waiting for AW and/or W
    WR_RESP     // B pending
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_RESP
  } rd_state_e;

endpackage

/* rtl/rab_params_cfg.svh */
// RAB configuration parameters
`ifndef RAB_PARAMS_CFG_SVH
`define RAB_PARAMS_CFG_SVH

// AXI-Lite bus
`define RAB_AXI_ADDR_WIDTH 32
`define RAB_AXI_DATA_WIDTH 64

// Register file, index 0 and 1 are the miss FIFOs
`define RAB_N_REGS 16
`define RAB_ADDR_LSB 3 // 8 bytes per register

`define RAB_VIRT_WIDTH 32
`define RAB_PHYS_WIDTH 40
`define RAB_N_FLAGS 4

`define RAB_MISS_ID_WIDTH 10
`define RAB_MH_FIFO_DEPTH 8

`endif
